//--- src/dma_pkg.sv
package dma_pkg;

  // widths and sizes
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int LEN_W        = 32;   // bytes per transfer
  localparam int TAG_W        = 8;
  localparam int CNT_W        = 16;   // t, p and bundle counters
  localparam int USER_W       = 65;   // header + first-p flag
  localparam int RAM_RD_W     = 288;
  localparam int RAM_DEPTH    = 8;    // bundle slots
  localparam int RAM_WR_DEPTH = 72;   // 32-bit words behind the slots
  localparam int RAM_SLOT_WORDS = RAM_RD_W / DATA_W;
  localparam int REG_SPACE    = 16;   // host addresses from here on hit the RAM
  localparam int N_REGS       = 13;

  // register map, word addresses
  localparam int A_START        = 0;
  localparam int A_DONE_READ    = 1;  // two banks
  localparam int A_DONE_WRITE   = 3;  // two banks
  localparam int A_OCM_BASE     = 5;  // two banks
  localparam int A_WEIGHTS_BASE = 7;
  localparam int A_BUNDLE_DONE  = 8;
  localparam int A_N_BUNDLES    = 9;
  localparam int A_W_DONE       = 10;
  localparam int A_X_DONE       = 11;
  localparam int A_O_DONE       = 12;

  typedef logic [ADDR_W-1:0]               addr_t;
  typedef logic [DATA_W-1:0]               data_t;
  typedef logic [LEN_W-1:0]                len_t;
  typedef logic [CNT_W-1:0]                cnt_t;
  typedef logic [TAG_W-1:0]                tag_t;
  typedef logic [$clog2(RAM_DEPTH)-1:0]    ram_rd_addr_t;
  typedef logic [$clog2(RAM_WR_DEPTH)-1:0] ram_wr_addr_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } reg_wr_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } reg_rd_t;

  // ready comes back on its own wire
  typedef struct packed {
    logic              valid;
    addr_t             addr;
    len_t              len;
    logic [USER_W-1:0] user;
  } desc_t;

  // one bundle record, msb first
  typedef struct packed {
    logic [63:0] header;
    cnt_t        max_t;
    cnt_t        max_p;
    len_t        w_bpt;
    len_t        w_bpt_p0;
    len_t        x_bpt;
    len_t        x_bpt_p0;
    addr_t       xb_base;
  } bundle_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_WAIT_RAM,
    SEQ_WAIT_WRITE,
    SEQ_EXEC
  } seq_state_e;

endpackage

//--- src/loop_counter.sv
`timescale 1ns/1ps

module loop_counter (
  input  logic          clk,
  input  logic          rstn,
  input  logic          i_load,
  input  logic          i_en,
  input  dma_pkg::cnt_t i_max,
  output logic          o_last_clk,
  output logic          o_first,
  output dma_pkg::cnt_t o_count
);

  dma_pkg::cnt_t max_m1;  // reload value kept for the wrap
  dma_pkg::cnt_t count;
  logic          first;

  always_ff @(posedge clk) begin
    if (i_load) max_m1 <= i_max - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      count <= '0;
      first <= 1'b0;
    end else if (i_load) begin
      count <= i_max - 1'b1;
      first <= 1'b1;
    end else if (i_en) begin
      first <= 1'b0;             // only the first step after a load
      if (count == '0) count <= max_m1;
      else             count <= count - 1'b1;
    end
  end

  assign o_last_clk = i_en && (count == '0);
  assign o_first    = first;
  assign o_count    = count;

endmodule

//--- src/bundle_ram.sv
`timescale 1ns/1ps

module bundle_ram (
  input  logic                          clk,
  input  logic                          i_we,
  input  dma_pkg::ram_wr_addr_t         i_wr_addr,
  input  dma_pkg::data_t                i_wr_data,
  input  logic                          i_re,
  input  dma_pkg::ram_rd_addr_t         i_rd_addr,
  output logic [dma_pkg::RAM_RD_W-1:0]  o_rd_data
);

  // word k of a slot sits at slot*9 + k, word 0 is the lsb word
  dma_pkg::data_t mem [dma_pkg::RAM_WR_DEPTH];

  logic [dma_pkg::RAM_RD_W-1:0] rd_q;

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // whole slot gathered in one cycle
  always_ff @(posedge clk) begin
    if (i_re) begin
      for (int k = 0; k < dma_pkg::RAM_SLOT_WORDS; k++) begin
        rd_q[k*dma_pkg::DATA_W +: dma_pkg::DATA_W] <=
          mem[int'(i_rd_addr) * dma_pkg::RAM_SLOT_WORDS + k];
      end
    end
  end

  assign o_rd_data = rd_q;

endmodule

//--- src/bundle_sequencer.sv
`timescale 1ns/1ps

module bundle_sequencer #(
  parameter bit PIXEL_MODE = 1'b0
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  i_start,
  input  dma_pkg::cnt_t         i_n_bundles,
  input  dma_pkg::addr_t        i_base,
  input  logic                  i_bundle_done,
  input  logic                  i_ram_valid,
  input  dma_pkg::bundle_t      i_bundle,
  input  logic                  i_ready,
  output logic                  o_ram_re,
  output dma_pkg::ram_rd_addr_t o_ram_addr,
  output logic                  o_bundle_done_clr,
  output dma_pkg::desc_t        o_desc,
  output logic                  o_idle
);

  dma_pkg::seq_state_e state, state_nxt;

  logic           xfer;
  logic           lc_t, lc_p, lc_b;
  logic           first_p;
  dma_pkg::cnt_t  count_b;
  dma_pkg::cnt_t  bundle_idx;
  dma_pkg::addr_t addr;
  dma_pkg::len_t  bpt, bpt_p0, len;
  logic [63:0]    header;
  logic           addr_load, addr_step;
  dma_pkg::addr_t addr_init;

  always_comb begin
    state_nxt = state;
    unique case (state)
      dma_pkg::SEQ_IDLE: begin
        if (i_start) state_nxt = dma_pkg::SEQ_WAIT_RAM;
      end
      dma_pkg::SEQ_WAIT_RAM: begin
        if (i_ram_valid) begin
          if (PIXEL_MODE) state_nxt = dma_pkg::SEQ_WAIT_WRITE;
          else            state_nxt = dma_pkg::SEQ_EXEC;
        end
      end
      dma_pkg::SEQ_WAIT_WRITE: begin
        if (i_bundle_done) state_nxt = dma_pkg::SEQ_EXEC;  // engine freed the input
      end
      dma_pkg::SEQ_EXEC: begin
        if (lc_b)      state_nxt = dma_pkg::SEQ_IDLE;      // last bundle finished
        else if (lc_p) state_nxt = dma_pkg::SEQ_WAIT_RAM;  // fetch next record
      end
      default: state_nxt = dma_pkg::SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) state <= dma_pkg::SEQ_IDLE;
    else       state <= state_nxt;
  end

  // request stays up until our data comes back, so a lost arbitration just retries
  assign o_ram_re   = (state == dma_pkg::SEQ_WAIT_RAM) && !i_ram_valid;
  assign bundle_idx = i_n_bundles - 1'b1 - count_b;  // bundle counter runs downward
  assign o_ram_addr = dma_pkg::ram_rd_addr_t'(bundle_idx);

  assign o_bundle_done_clr = PIXEL_MODE && (state == dma_pkg::SEQ_WAIT_WRITE) && i_bundle_done;

  // bundle parameters for this stream
  always_ff @(posedge clk) begin
    if (i_ram_valid) begin
      header <= i_bundle.header;
      bpt    <= PIXEL_MODE ? i_bundle.x_bpt    : i_bundle.w_bpt;
      bpt_p0 <= PIXEL_MODE ? i_bundle.x_bpt_p0 : i_bundle.w_bpt_p0;
    end
  end

  // weights: one running address from start, pixels: per bundle, stepped once per t loop
  assign addr_load = PIXEL_MODE ? i_ram_valid      : i_start;
  assign addr_init = PIXEL_MODE ? i_bundle.xb_base : i_base;
  assign addr_step = PIXEL_MODE ? lc_t             : xfer;

  always_ff @(posedge clk) begin
    if (addr_load)      addr <= addr_init;
    else if (addr_step) addr <= addr + dma_pkg::addr_t'(len);
  end

  assign len  = first_p ? bpt_p0 : bpt;
  assign xfer = o_desc.valid && i_ready;

  assign o_desc = '{
    valid: (state == dma_pkg::SEQ_EXEC),
    addr:  addr,
    len:   len,
    user:  {header, first_p}
  };

  assign o_idle = (state == dma_pkg::SEQ_IDLE);

  loop_counter u_cnt_t (
    .clk(clk), .rstn(rstn), .i_load(i_ram_valid), .i_en(xfer), .i_max(i_bundle.max_t),
    .o_last_clk(lc_t), .o_first(), .o_count()
  );

  loop_counter u_cnt_p (
    .clk(clk), .rstn(rstn), .i_load(i_ram_valid), .i_en(lc_t), .i_max(i_bundle.max_p),
    .o_last_clk(lc_p), .o_first(first_p), .o_count()
  );

  loop_counter u_cnt_b (
    .clk(clk), .rstn(rstn), .i_load(i_start), .i_en(lc_p), .i_max(i_n_bundles),
    .o_last_clk(lc_b), .o_first(), .o_count(count_b)
  );

endmodule

//--- src/dma_regs.sv
`timescale 1ns/1ps

module dma_regs (
  input  logic             clk,
  input  logic             rstn,
  input  dma_pkg::reg_wr_t i_wr,
  input  dma_pkg::reg_rd_t i_rd,
  input  logic             i_w_idle,
  input  logic             i_x_idle,
  input  logic             i_bundle_done_clr,
  input  logic             i_o_valid,
  input  logic             i_o_ready,
  input  logic             i_o_last,
  input  dma_pkg::len_t    i_o_bpt,
  input  logic             i_os_valid,
  input  dma_pkg::tag_t    i_os_tag,
  input  logic [3:0]       i_os_error,
  input  logic             i_od_ready,
  output dma_pkg::data_t   o_rd_data,
  output logic             o_start,
  output dma_pkg::cnt_t    o_n_bundles,
  output dma_pkg::addr_t   o_weights_base,
  output logic             o_bundle_done,
  output dma_pkg::desc_t   o_od,
  output dma_pkg::tag_t    o_od_tag
);

  dma_pkg::data_t cfg [dma_pkg::N_REGS];
  dma_pkg::data_t rd_q;

  logic           bank;      // bank the write DMA is filling
  logic           bank_nxt;
  logic           got_last;  // engine finished its previous packet
  logic           od_valid;
  logic           od_issue;
  logic           os_ok;
  dma_pkg::addr_t od_addr;
  dma_pkg::len_t  od_len;

  always_ff @(posedge clk) begin
    if (i_rd.en) begin
      if (i_rd.addr < dma_pkg::N_REGS) rd_q <= cfg[i_rd.addr[3:0]];
      else                             rd_q <= '0;
    end
  end

  assign bank_nxt = ~bank;
  assign os_ok    = i_os_valid && (i_os_error == '0);
  assign od_issue = i_od_ready && i_o_valid && got_last &&
                    cfg[dma_pkg::A_DONE_READ + int'(bank_nxt)][0];

  // output ping-pong
  always_ff @(posedge clk) begin
    if (!rstn) begin
      bank     <= 1'b1;  // flips to 0 on the first descriptor
      got_last <= 1'b1;
      od_valid <= 1'b0;
    end else begin
      if (i_o_valid && i_o_ready && i_o_last) got_last <= 1'b1;
      if (od_issue) begin
        bank     <= bank_nxt;
        got_last <= 1'b0;
        od_valid <= 1'b1;
      end else if (od_valid && i_od_ready) begin
        od_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (od_issue) begin
      od_addr <= cfg[dma_pkg::A_OCM_BASE + int'(bank_nxt)];
      od_len  <= i_o_bpt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int k = 0; k < dma_pkg::N_REGS; k++) begin
        cfg[k] <= '0;
      end
      cfg[dma_pkg::A_DONE_READ]     <= dma_pkg::data_t'(1);  // both banks free
      cfg[dma_pkg::A_DONE_READ + 1] <= dma_pkg::data_t'(1);
      cfg[dma_pkg::A_BUNDLE_DONE]   <= dma_pkg::data_t'(1);
    end else begin
      if (cfg[dma_pkg::A_START][0]) cfg[dma_pkg::A_START] <= '0;  // one cycle pulse
      if (i_bundle_done_clr) cfg[dma_pkg::A_BUNDLE_DONE] <= '0;
      if (od_issue) begin
        cfg[dma_pkg::A_DONE_READ + int'(bank_nxt)]  <= '0;
        cfg[dma_pkg::A_DONE_WRITE + int'(bank_nxt)] <= '0;
      end
      if (os_ok) cfg[dma_pkg::A_DONE_WRITE + int'(i_os_tag[0])] <= dma_pkg::data_t'(1);
      cfg[dma_pkg::A_W_DONE] <= dma_pkg::data_t'(i_w_idle);
      cfg[dma_pkg::A_X_DONE] <= dma_pkg::data_t'(i_x_idle);
      if (cfg[dma_pkg::A_START][0] || i_o_valid) cfg[dma_pkg::A_O_DONE] <= '0;
      else if (got_last && os_ok)                cfg[dma_pkg::A_O_DONE] <= dma_pkg::data_t'(1);
      // host write lands last and wins
      if (i_wr.en && (i_wr.addr < dma_pkg::N_REGS)) cfg[i_wr.addr[3:0]] <= i_wr.data;
    end
  end

  assign o_rd_data      = rd_q;
  assign o_start        = cfg[dma_pkg::A_START][0];
  assign o_n_bundles    = dma_pkg::cnt_t'(cfg[dma_pkg::A_N_BUNDLES]);
  assign o_weights_base = cfg[dma_pkg::A_WEIGHTS_BASE];
  assign o_bundle_done  = cfg[dma_pkg::A_BUNDLE_DONE][0];
  assign o_od           = '{valid: od_valid, addr: od_addr, len: od_len, user: '0};
  assign o_od_tag       = dma_pkg::tag_t'(bank);

endmodule

//--- src/dma_controller.sv
`timescale 1ns/1ps

module dma_controller (
  input  logic             clk,
  input  logic             rstn,
  input  dma_pkg::reg_wr_t i_reg_wr,
  input  dma_pkg::reg_rd_t i_reg_rd,
  input  logic             i_o_valid,
  input  logic             i_o_ready,
  input  logic             i_o_last,
  input  dma_pkg::len_t    i_o_bpt,
  input  logic             i_os_valid,
  input  dma_pkg::tag_t    i_os_tag,
  input  logic [3:0]       i_os_error,
  input  logic             i_od_ready,
  input  logic             i_wd_ready,
  input  logic             i_xd_ready,
  output logic             o_reg_wr_ack,
  output logic             o_reg_rd_ack,
  output dma_pkg::data_t   o_reg_rd_data,
  output dma_pkg::desc_t   o_od,
  output dma_pkg::tag_t    o_od_tag,
  output dma_pkg::desc_t   o_wd,
  output dma_pkg::desc_t   o_xd
);

  dma_pkg::reg_wr_t             regs_wr;
  logic                         ram_we, ram_re;
  dma_pkg::ram_wr_addr_t        ram_wr_addr;
  dma_pkg::ram_rd_addr_t        ram_rd_addr, w_ram_addr, x_ram_addr;
  logic [dma_pkg::RAM_RD_W-1:0] ram_rd_data;
  dma_pkg::bundle_t             ram_bundle;
  logic                         w_ram_re, x_ram_re, w_ram_valid, x_ram_valid;
  logic                         start, bundle_done, bundle_done_clr, w_idle, x_idle;
  dma_pkg::cnt_t                n_bundles;
  dma_pkg::addr_t               weights_base;

  assign o_reg_wr_ack = 1'b1;
  assign o_reg_rd_ack = 1'b1;

  // address split between register file and bundle table
  assign regs_wr = '{en: i_reg_wr.en && (i_reg_wr.addr < dma_pkg::REG_SPACE),
                     addr: i_reg_wr.addr, data: i_reg_wr.data};
  assign ram_we = i_reg_wr.en && (i_reg_wr.addr >= dma_pkg::REG_SPACE) &&
                  (i_reg_wr.addr < dma_pkg::REG_SPACE + dma_pkg::RAM_WR_DEPTH);
  assign ram_wr_addr = dma_pkg::ram_wr_addr_t'(i_reg_wr.addr - dma_pkg::REG_SPACE);

  // pixels first, a losing weights request is simply held
  assign ram_re      = x_ram_re || w_ram_re;
  assign ram_rd_addr = x_ram_re ? x_ram_addr : w_ram_addr;
  assign ram_bundle  = dma_pkg::bundle_t'(ram_rd_data[$bits(dma_pkg::bundle_t)-1:0]);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      x_ram_valid <= 1'b0;
      w_ram_valid <= 1'b0;
    end else begin
      x_ram_valid <= x_ram_re;
      w_ram_valid <= w_ram_re && !x_ram_re;
    end
  end

  dma_regs u_regs (
    .clk(clk), .rstn(rstn), .i_wr(regs_wr), .i_rd(i_reg_rd),
    .i_w_idle(w_idle), .i_x_idle(x_idle), .i_bundle_done_clr(bundle_done_clr),
    .i_o_valid(i_o_valid), .i_o_ready(i_o_ready), .i_o_last(i_o_last), .i_o_bpt(i_o_bpt),
    .i_os_valid(i_os_valid), .i_os_tag(i_os_tag), .i_os_error(i_os_error),
    .i_od_ready(i_od_ready), .o_rd_data(o_reg_rd_data), .o_start(start),
    .o_n_bundles(n_bundles), .o_weights_base(weights_base), .o_bundle_done(bundle_done),
    .o_od(o_od), .o_od_tag(o_od_tag)
  );

  bundle_ram u_ram (
    .clk(clk), .i_we(ram_we), .i_wr_addr(ram_wr_addr), .i_wr_data(i_reg_wr.data),
    .i_re(ram_re), .i_rd_addr(ram_rd_addr), .o_rd_data(ram_rd_data)
  );

  bundle_sequencer #(.PIXEL_MODE(1'b0)) u_wseq (
    .clk(clk), .rstn(rstn), .i_start(start), .i_n_bundles(n_bundles), .i_base(weights_base),
    .i_bundle_done(bundle_done), .i_ram_valid(w_ram_valid), .i_bundle(ram_bundle),
    .i_ready(i_wd_ready), .o_ram_re(w_ram_re), .o_ram_addr(w_ram_addr),
    .o_bundle_done_clr(), .o_desc(o_wd), .o_idle(w_idle)
  );

  bundle_sequencer #(.PIXEL_MODE(1'b1)) u_xseq (
    .clk(clk), .rstn(rstn), .i_start(start), .i_n_bundles(n_bundles), .i_base(weights_base),
    .i_bundle_done(bundle_done), .i_ram_valid(x_ram_valid), .i_bundle(ram_bundle),
    .i_ready(i_xd_ready), .o_ram_re(x_ram_re), .o_ram_addr(x_ram_addr),
    .o_bundle_done_clr(bundle_done_clr), .o_desc(o_xd), .o_idle(x_idle)
  );

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    rstn = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

//--- tb/dma_controller_props.sv
`timescale 1ns/1ps

module dma_controller_props (
  input logic           clk,
  input logic           rstn,
  input logic           start,
  input logic           i_wd_ready,
  input logic           i_xd_ready,
  input logic           i_od_ready,
  input dma_pkg::desc_t o_wd,
  input dma_pkg::desc_t o_xd,
  input dma_pkg::desc_t o_od
);

  wd_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_wd.valid && !i_wd_ready |=> o_wd.valid && $stable(o_wd))
    else $error("weights descriptor changed before ready");

  xd_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_xd.valid && !i_xd_ready |=> o_xd.valid && $stable(o_xd))
    else $error("pixel descriptor changed before ready");

  od_hold: assert property (@(posedge clk) disable iff (!rstn)
    o_od.valid && !i_od_ready |=> o_od.valid && $stable(o_od))
    else $error("output descriptor changed before ready");

  start_pulse: assert property (@(posedge clk) disable iff (!rstn) start |=> !start)
    else $error("start held longer than one cycle");

  // nothing leaves the controller straight out of reset
  reset_idle: assert property (@(posedge clk)
    !rstn |=> !o_wd.valid && !o_xd.valid && !o_od.valid)
    else $error("descriptor valid high after reset");

endmodule

bind dma_controller dma_controller_props u_props (
  .clk(clk), .rstn(rstn), .start(start), .i_wd_ready(i_wd_ready),
  .i_xd_ready(i_xd_ready), .i_od_ready(i_od_ready), .o_wd(o_wd), .o_xd(o_xd), .o_od(o_od)
);

//--- tb/dma_controller_tb.sv
`timescale 1ns/1ps

module dma_controller_tb;

  typedef struct packed {
    int             first;  // first record of the bundle table
    int             n;
    dma_pkg::addr_t wbase;
    logic           stall;  // random ready on both streams
  } test_t;

  typedef struct packed {
    dma_pkg::len_t bpt;
    logic          release_rd;  // host frees the bank while the packet waits
    logic [3:0]    err;
  } pkt_t;

  logic             clk, rstn;
  dma_pkg::reg_wr_t reg_wr;
  dma_pkg::reg_rd_t reg_rd;
  logic             o_valid, o_ready, o_last, os_valid;
  logic             wd_ready = 1'b1;
  logic             xd_ready = 1'b1;
  logic             od_ready = 1'b1;
  dma_pkg::len_t    o_bpt;
  dma_pkg::tag_t    os_tag, od_tag;
  logic [3:0]       os_error;
  logic             wr_ack, rd_ack;
  dma_pkg::data_t   rd_data;
  dma_pkg::desc_t   od, wd, xd;

  dma_pkg::bundle_t recs [5];
  test_t tests [3] = '{'{0, 2, 32'h1000_0000, 1'b0}, '{2, 3, 32'h2000_0000, 1'b1},
                       '{0, 5, 32'h3000_0040, 1'b1}};
  pkt_t pkts [4] = '{'{32'h40, 1'b0, 4'h0}, '{32'h80, 1'b0, 4'h3},
                     '{32'h20, 1'b1, 4'h0}, '{32'h100, 1'b1, 4'h0}};
  dma_pkg::addr_t ocm_base [2] = '{32'h4000_0000, 32'h4800_0100};

  dma_pkg::desc_t wq[$], xq[$], oq[$];
  dma_pkg::tag_t  tq[$];
  int          xstart [8];  // pixel count reached before each bundle
  int          w_seen, x_seen, od_seen, n_checks, n_errors, limit_cycles;
  logic        stall_mode = 1'b0;
  logic [31:0] rng = 32'ha002_3cad;

  tb_clock u_clock (.clk(clk), .rstn(rstn));

  dma_controller i_dut (
    .clk(clk), .rstn(rstn), .i_reg_wr(reg_wr), .i_reg_rd(reg_rd), .i_o_valid(o_valid),
    .i_o_ready(o_ready), .i_o_last(o_last), .i_o_bpt(o_bpt), .i_os_valid(os_valid),
    .i_os_tag(os_tag), .i_os_error(os_error), .i_od_ready(od_ready), .i_wd_ready(wd_ready),
    .i_xd_ready(xd_ready), .o_reg_wr_ack(wr_ack), .o_reg_rd_ack(rd_ack),
    .o_reg_rd_data(rd_data), .o_od(od), .o_od_tag(od_tag), .o_wd(wd), .o_xd(xd)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic dma_pkg::bundle_t mk_rec(input logic [63:0] hdr, input int mt, input int mp,
      input dma_pkg::len_t w, input dma_pkg::len_t w0, input dma_pkg::len_t x,
      input dma_pkg::len_t x0, input dma_pkg::addr_t xb);
    return '{hdr, dma_pkg::cnt_t'(mt), dma_pkg::cnt_t'(mp), w, w0, x, x0, xb};
  endfunction

  task automatic check_desc(input string name, input dma_pkg::desc_t got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input dma_pkg::data_t got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input dma_pkg::tag_t got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  // ready changes on the falling edge and handshakes are sampled just after it
  always @(negedge clk) begin
    if (stall_mode) begin
      rng = xorshift32(rng);
      wd_ready = rng[0] | rng[1];
      xd_ready = rng[2] | rng[3];
      od_ready = rng[4] & rng[5];
    end else begin
      wd_ready = 1'b1;
      xd_ready = 1'b1;
      od_ready = 1'b1;
    end
  end

  always @(negedge clk) begin
    #1;
    if (wd.valid && wd_ready) begin
      if (wq.size() == 0) begin
        n_errors++;
        $display("unexpected weights descriptor at %0t", $time);
      end else check_desc("o_wd", wd, wq.pop_front());
      w_seen++;
    end
    if (xd.valid && xd_ready) begin
      if (xq.size() == 0) begin
        n_errors++;
        $display("unexpected pixel descriptor at %0t", $time);
      end else check_desc("o_xd", xd, xq.pop_front());
      x_seen++;
    end
    if (od.valid && od_ready) begin
      if (oq.size() == 0) begin
        n_errors++;
        $display("unexpected output descriptor at %0t", $time);
      end else begin
        check_desc("o_od", od, oq.pop_front());
        check_tag("o_od_tag", od_tag, tq.pop_front());
      end
      od_seen++;
    end
  end

  // called on a falling edge and returns on the next one
  task automatic reg_write(input int addr, input dma_pkg::data_t data);
    reg_wr = '{en: 1'b1, addr: dma_pkg::addr_t'(addr), data: data};
    @(negedge clk);
    check_bit("o_reg_wr_ack", wr_ack, 1'b1);
    reg_wr = '0;
  endtask

  task automatic check_reg(input string name, input int addr, input dma_pkg::data_t exp);
    reg_rd = '{en: 1'b1, addr: dma_pkg::addr_t'(addr)};
    @(negedge clk);
    check_bit("o_reg_rd_ack", rd_ack, 1'b1);
    reg_rd = '0;
    check_data(name, rd_data, exp);
  endtask

  // reference model of both sequencers
  task automatic expand(input test_t t, output int nw, output int nx);
    dma_pkg::bundle_t r;
    dma_pkg::addr_t   wa, xa;
    dma_pkg::len_t    len;
    logic             first;
    nw = 0;
    nx = 0;
    wa = t.wbase;
    for (int b = 0; b < t.n; b++) begin
      r = recs[t.first + b];
      xa = r.xb_base;
      xstart[b] = nx;
      for (int pp = 0; pp < int'(r.max_p); pp++) begin
        first = (pp == 0);
        for (int tt = 0; tt < int'(r.max_t); tt++) begin
          len = first ? r.w_bpt_p0 : r.w_bpt;
          wq.push_back('{1'b1, wa, len, {r.header, first}});
          wa = wa + len;   // weights step every transfer
          len = first ? r.x_bpt_p0 : r.x_bpt;
          xq.push_back('{1'b1, xa, len, {r.header, first}});
          nw++;
          nx++;
        end
        xa = xa + (first ? r.x_bpt_p0 : r.x_bpt);  // pixels step once per t loop
      end
    end
  endtask

  task automatic run_bundles(input int k);
    test_t            t;
    dma_pkg::bundle_t r;
    int               nw, nx, errs0;
    t = tests[k];
    errs0 = n_errors;
    for (int b = 0; b < t.n; b++) begin
      r = recs[t.first + b];
      for (int w = 0; w < 8; w++) begin
        reg_write(dma_pkg::REG_SPACE + b * dma_pkg::RAM_SLOT_WORDS + w, r[w*32 +: 32]);
      end
    end
    reg_write(dma_pkg::A_N_BUNDLES, t.n);
    reg_write(dma_pkg::A_WEIGHTS_BASE, t.wbase);
    reg_write(dma_pkg::A_BUNDLE_DONE, 0);  // hold pixels until the host releases them
    expand(t, nw, nx);
    w_seen = 0;
    x_seen = 0;
    stall_mode = t.stall;
    reg_write(dma_pkg::A_START, 1);
    for (int b = 0; b < t.n; b++) begin
      wait (x_seen == xstart[b]);
      repeat (12) @(negedge clk);
      if (x_seen != xstart[b] || xd.valid) begin
        n_errors++;
        $display("pixel descriptor of bundle %0d issued before BUNDLE_DONE", b);
      end
      reg_write(dma_pkg::A_BUNDLE_DONE, 1);
    end
    wait (w_seen == nw && x_seen == nx);
    repeat (4) @(negedge clk);
    stall_mode = 1'b0;
    check_reg("W_DONE", dma_pkg::A_W_DONE, 1);
    check_reg("X_DONE", dma_pkg::A_X_DONE, 1);
    $display("test bundles %0d: %0d weights, %0d pixels, %0d errors",
             k, nw, nx, n_errors - errs0);
  endtask

  task automatic run_output();
    pkt_t pk;
    int   errs0;
    errs0 = n_errors;
    od_seen = 0;
    stall_mode = 1'b1;  // output ready stalls too
    for (int p = 0; p < 4; p++) begin
      pk = pkts[p];
      oq.push_back('{1'b1, ocm_base[p % 2], pk.bpt, '0});
      tq.push_back(dma_pkg::tag_t'(p % 2));
      o_valid = 1'b1;   // first beat waits on o_ready
      o_bpt = pk.bpt;
      if (pk.release_rd) begin
        repeat (10) @(negedge clk);
        if (od_seen != p) begin
          n_errors++;
          $display("output descriptor %0d issued while DONE_READ was clear", p);
        end
        reg_write(dma_pkg::A_DONE_READ + p % 2, 1);
      end
      wait (od_seen == p + 1);
      @(negedge clk);
      o_ready = 1'b1;
      o_last = 1'b1;
      @(negedge clk);
      o_valid = 1'b0;
      o_ready = 1'b0;
      o_last = 1'b0;
      os_valid = 1'b1;
      os_tag = dma_pkg::tag_t'(p % 2);
      os_error = pk.err;
      @(negedge clk);
      os_valid = 1'b0;
      os_error = '0;
      check_reg("DONE_WRITE", dma_pkg::A_DONE_WRITE + p % 2, dma_pkg::data_t'(pk.err == 0));
    end
    stall_mode = 1'b0;
    check_reg("O_DONE", dma_pkg::A_O_DONE, 1);
    $display("test output: 4 packets, %0d errors", n_errors - errs0);
  endtask

  initial begin
    int total;
    reg_wr = '0;
    reg_rd = '0;
    o_valid = 1'b0;
    o_ready = 1'b0;
    o_last = 1'b0;
    o_bpt = '0;
    os_valid = 1'b0;
    os_tag = '0;
    os_error = '0;
    recs[0] = mk_rec(64'h0123_4567_89ab_cdef, 2, 3, 32'h100, 32'h80, 32'h40, 32'h20,
                     32'h5000_0000);
    recs[1] = mk_rec(64'hfeed_0001_0000_0002, 3, 1, 32'h200, 32'h180, 32'h60, 32'h30,
                     32'h5100_0000);
    recs[2] = mk_rec(64'h8000_0000_0000_0003, 1, 4, 32'h20, 32'h10, 32'h8, 32'h4,
                     32'h5200_0010);
    recs[3] = mk_rec(64'h0000_00ff_1234_0004, 4, 2, 32'h1000, 32'h800, 32'h100, 32'h80,
                     32'h5300_0000);
    recs[4] = mk_rec(64'h5a5a_a5a5_0f0f_0005, 2, 2, 32'h44, 32'h24, 32'h14, 32'hc,
                     32'h5400_0200);
    total = 4;
    foreach (tests[k]) begin
      for (int b = 0; b < tests[k].n; b++) begin
        total += 2 * int'(recs[tests[k].first + b].max_t) * int'(recs[tests[k].first + b].max_p);
      end
    end
    limit_cycles = total * 40 + 2000;
    wait (rstn === 1'b1);
    @(negedge clk);
    check_reg("W_DONE", dma_pkg::A_W_DONE, 1);
    check_reg("X_DONE", dma_pkg::A_X_DONE, 1);
    reg_write(dma_pkg::A_OCM_BASE, ocm_base[0]);
    reg_write(dma_pkg::A_OCM_BASE + 1, ocm_base[1]);
    reg_write(dma_pkg::A_WEIGHTS_BASE, 32'hcafe_0000);
    check_reg("OCM_BASE0", dma_pkg::A_OCM_BASE, ocm_base[0]);
    check_reg("OCM_BASE1", dma_pkg::A_OCM_BASE + 1, ocm_base[1]);
    check_reg("WEIGHTS_BASE", dma_pkg::A_WEIGHTS_BASE, 32'hcafe_0000);
    check_reg("DONE_READ0", dma_pkg::A_DONE_READ, 1);
    $display("test regs: %0d errors", n_errors);
    foreach (tests[k]) run_bundles(k);
    run_output();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run took more than %0d cycles", limit_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- verilog.f
src/dma_pkg.sv
src/loop_counter.sv
src/bundle_ram.sv
src/bundle_sequencer.sv
src/dma_regs.sv
src/dma_controller.sv
tb/tb_clock.sv
tb/dma_controller_props.sv
tb/dma_controller_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f verilog.f \
  --top-module dma_controller_tb -Mdir obj_dir

out=$(./obj_dir/Vdma_controller_tb)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
